//--- all.f
+incdir+include
src/dma_pkg.sv
src/dma_slave_port.sv
src/dma_reg_file.sv
src/dma_ch_sel.sv
src/dma_engine.sv
src/dma_master_port.sv
src/dma_top.sv
tb/tb_clk_gen.sv
tb/tb_wb_mem.sv
tb/tb_dma.sv

//--- include/dma_defs.svh
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define DMA_DW        32
`define DMA_SELW      4

// ----------------------------------------
// Channels
// ----------------------------------------
`define DMA_CH_COUNT  2
`define DMA_CHW       1
`define DMA_SZW       12

// Slave address map, index in [3:2], channel from bit 4 up
`define DMA_IDX_LSB   2
`define DMA_CH_LSB    4

// CSR bit positions
`define DMA_CSR_EN    0
`define DMA_CSR_INE   1
`define DMA_CSR_DONE  2
`define DMA_CSR_ERR   3

`endif

//--- run.sh
#!/bin/bash
# Build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module tb_dma -o sim_dma
./obj_dir/sim_dma | tee sim.log

# Pass only if the testbench printed its pass line
grep -qx "STATUS: PASS" sim.log
echo "Simulation passed"

//--- src/dma_ch_sel.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_ch_sel (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic [`DMA_CH_COUNT-1:0] en_i,
	input  dma_pkg::desc_t           desc_i [`DMA_CH_COUNT],
	input  dma_pkg::de_status_t      de_stat_i,
	output logic                     de_start_o,
	output dma_pkg::desc_t           desc_o,
	output logic [`DMA_CHW-1:0]      de_ch_o
);
	import dma_pkg::*;

	logic                busy_q;
	logic [`DMA_CHW-1:0] ch_q;	// Current, or last served
	logic [`DMA_CHW-1:0] next_ch;
	logic                found;

	// First enabled channel after the last one served
	always_comb begin
		found   = 1'b0;
		next_ch = ch_q;
		for (int i = 1; i <= `DMA_CH_COUNT; i++) begin
			if (!found && en_i[(int'(ch_q) + i) % `DMA_CH_COUNT]) begin
				found   = 1'b1;
				next_ch = `DMA_CHW'((int'(ch_q) + i) % `DMA_CH_COUNT);
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q     <= 1'b0;
			de_start_o <= 1'b0;
			ch_q       <= `DMA_CHW'(`DMA_CH_COUNT - 1);	// Channel 0 goes first
		end else begin
			de_start_o <= 1'b0;
			if (!busy_q && found) begin
				busy_q     <= 1'b1;
				de_start_o <= 1'b1;
				ch_q       <= next_ch;
			end else if (de_stat_i.done || de_stat_i.err)
				busy_q <= 1'b0;
		end
	end

	assign desc_o  = desc_i[ch_q];
	assign de_ch_o = ch_q;

	a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		de_start_o |-> !$past(busy_q));
	// Engine only reports while a job is held here
	a_stat_in_job: assert property (@(posedge clk_i) disable iff (rst_i)
		(de_stat_i.done || de_stat_i.err) |-> busy_q && !de_start_o);

endmodule

//--- src/dma_engine.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_engine (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                de_start_i,
	input  dma_pkg::desc_t      desc_i,
	input  logic                m_drdy_i,
	input  logic                m_err_i,
	input  logic [`DMA_DW-1:0]  m_rdata_i,
	output logic                m_go_o,
	output dma_pkg::bus_req_t   m_req_o,
	output dma_pkg::de_status_t stat_o
);
	import dma_pkg::*;

	de_state_e           state_q;
	logic                err_q;
	logic [`DMA_DW-1:0]  src_q;
	logic [`DMA_DW-1:0]  dst_q;
	logic [`DMA_SZW-1:0] cnt_q;	// Words still to move

	// ----------------------------------------
	// Copy FSM
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= DE_IDLE;
			err_q   <= 1'b0;
		end else begin
			case (state_q)
				DE_IDLE: begin
					if (de_start_i) begin
						err_q   <= 1'b0;
						state_q <= (desc_i.size == '0) ? DE_END : DE_READ;
					end
				end
				DE_READ: begin
					if (m_err_i) begin
						err_q   <= 1'b1;
						state_q <= DE_END;
					end else if (m_drdy_i)
						state_q <= DE_WRITE;
				end
				DE_WRITE: begin
					if (m_err_i) begin
						err_q   <= 1'b1;
						state_q <= DE_END;
					end else if (m_drdy_i)
						state_q <= (cnt_q == `DMA_SZW'd1) ? DE_END : DE_READ;
				end
				DE_END: state_q <= DE_IDLE;	// Status pulse lasts this one cycle
				default: state_q <= DE_IDLE;
			endcase
		end
	end

	// Job pointers, loaded at start and stepped after each write
	always_ff @(posedge clk_i) begin
		if (state_q == DE_IDLE && de_start_i) begin
			src_q <= desc_i.src;
			dst_q <= desc_i.dst;
			cnt_q <= desc_i.size;
		end else if (state_q == DE_WRITE && m_drdy_i) begin
			src_q <= src_q + `DMA_DW'd4;
			dst_q <= dst_q + `DMA_DW'd4;
			cnt_q <= cnt_q - `DMA_SZW'd1;
		end
	end

	// ----------------------------------------
	// Master request and status
	// ----------------------------------------
	assign m_go_o      = (state_q == DE_READ) || (state_q == DE_WRITE);
	assign m_req_o.we  = (state_q == DE_WRITE);
	assign m_req_o.adr = (state_q == DE_WRITE) ? dst_q : src_q;
	assign m_req_o.dat = m_rdata_i;	// Held by the master until next read

	assign stat_o.done = (state_q == DE_END) && !err_q;
	assign stat_o.err  = (state_q == DE_END) && err_q;

endmodule

//--- src/dma_master_port.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_master_port (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 go_i,
	input  dma_pkg::bus_req_t    req_i,
	input  logic [`DMA_DW-1:0]   wbm_dat_i,
	input  logic                 wbm_ack_i,
	input  logic                 wbm_err_i,
	output logic                 drdy_o,
	output logic                 err_o,
	output logic [`DMA_DW-1:0]   rdata_o,
	output logic [`DMA_DW-1:0]   wbm_adr_o,
	output logic [`DMA_DW-1:0]   wbm_dat_o,
	output logic [`DMA_SELW-1:0] wbm_sel_o,
	output logic                 wbm_we_o,
	output logic                 wbm_cyc_o,
	output logic                 wbm_stb_o
);
	import dma_pkg::*;

	logic start;

	// No new cycle while the previous outcome is being reported
	assign start = go_i && !wbm_cyc_o && !drdy_o && !err_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wbm_cyc_o <= 1'b0;
			wbm_stb_o <= 1'b0;
			drdy_o    <= 1'b0;
			err_o     <= 1'b0;
		end else begin
			drdy_o <= 1'b0;
			err_o  <= 1'b0;
			if (wbm_cyc_o) begin
				if (wbm_ack_i || wbm_err_i) begin
					wbm_cyc_o <= 1'b0;
					wbm_stb_o <= 1'b0;
					drdy_o    <= wbm_ack_i;
					err_o     <= wbm_err_i & ~wbm_ack_i;
				end
			end else if (start) begin
				wbm_cyc_o <= 1'b1;
				wbm_stb_o <= 1'b1;
			end
		end
	end

	// Bus fields frozen for the whole cycle
	always_ff @(posedge clk_i) begin
		if (start) begin
			wbm_adr_o <= req_i.adr;
			wbm_dat_o <= req_i.dat;
			wbm_we_o  <= req_i.we;
		end
		if (wbm_cyc_o && wbm_ack_i && !wbm_we_o)
			rdata_o <= wbm_dat_i;	// Only reads update it
	end

	assign wbm_sel_o = {`DMA_SELW{1'b1}};

	a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wbm_stb_o |-> wbm_cyc_o);

endmodule

//--- src/dma_pkg.sv
`include "dma_defs.svh"

package dma_pkg;

	// ----------------------------------------
	// Register select and engine states
	// ----------------------------------------
	typedef enum logic [1:0] {
		REG_CSR = 2'd0,
		REG_SRC = 2'd1,
		REG_DST = 2'd2,
		REG_SZ  = 2'd3
	} reg_idx_e;

	typedef enum logic [1:0] {
		DE_IDLE,
		DE_READ,
		DE_WRITE,
		DE_END
	} de_state_e;

	// ----------------------------------------
	// Grouped signals between blocks
	// ----------------------------------------
	typedef struct packed {
		logic                we;
		logic                re;
		logic [`DMA_CHW-1:0] ch;
		reg_idx_e            idx;
		logic [`DMA_DW-1:0]  wdata;
	} reg_acc_t;

	typedef struct packed {
		logic [`DMA_DW-1:0]  src;
		logic [`DMA_DW-1:0]  dst;
		logic [`DMA_SZW-1:0] size;	// Words to copy
	} desc_t;

	typedef struct packed {
		logic [`DMA_DW-1:0] adr;
		logic [`DMA_DW-1:0] dat;
		logic               we;
	} bus_req_t;

	typedef struct packed {
		logic done;
		logic err;
	} de_status_t;

endpackage

//--- src/dma_reg_file.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_reg_file (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  dma_pkg::reg_acc_t        acc_i,
	input  logic [`DMA_CHW-1:0]      de_ch_i,
	input  dma_pkg::de_status_t      de_stat_i,
	output logic [`DMA_DW-1:0]       rdata_o,
	output logic [`DMA_CH_COUNT-1:0] en_o,
	output dma_pkg::desc_t           desc_o [`DMA_CH_COUNT],
	output logic                     inta_o
);
	import dma_pkg::*;

	logic [`DMA_CH_COUNT-1:0] en_q;
	logic [`DMA_CH_COUNT-1:0] ine_q;
	logic [`DMA_CH_COUNT-1:0] done_q;
	logic [`DMA_CH_COUNT-1:0] err_q;

	logic [`DMA_DW-1:0]  src_q [`DMA_CH_COUNT];
	logic [`DMA_DW-1:0]  dst_q [`DMA_CH_COUNT];
	logic [`DMA_SZW-1:0] sz_q  [`DMA_CH_COUNT];

	logic [`DMA_DW-1:0] csr_word;

	// ----------------------------------------
	// CSR bits
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			en_q   <= '0;
			ine_q  <= '0;
			done_q <= '0;
			err_q  <= '0;
		end else begin
			for (int c = 0; c < `DMA_CH_COUNT; c++) begin
				if (acc_i.we && acc_i.idx == REG_CSR && acc_i.ch == `DMA_CHW'(c)) begin
					en_q[c]   <= acc_i.wdata[`DMA_CSR_EN];
					ine_q[c]  <= acc_i.wdata[`DMA_CSR_INE];
					done_q[c] <= 1'b0;
					err_q[c]  <= 1'b0;
				end
				// End of job wins over a CSR write in the same cycle
				if ((de_stat_i.done || de_stat_i.err) && de_ch_i == `DMA_CHW'(c)) begin
					en_q[c] <= 1'b0;
					if (de_stat_i.done)
						done_q[c] <= 1'b1;
					if (de_stat_i.err)
						err_q[c] <= 1'b1;
				end
			end
		end
	end

	// ----------------------------------------
	// Addresses and word count
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		for (int c = 0; c < `DMA_CH_COUNT; c++) begin
			if (acc_i.we && acc_i.ch == `DMA_CHW'(c)) begin
				case (acc_i.idx)
					REG_SRC: src_q[c] <= acc_i.wdata;
					REG_DST: dst_q[c] <= acc_i.wdata;
					REG_SZ:  sz_q[c]  <= acc_i.wdata[`DMA_SZW-1:0];	// Upper bits dropped
					default: ;
				endcase
			end
		end
	end

	// Read mux, answers in the access cycle
	always_comb begin
		csr_word = '0;
		csr_word[`DMA_CSR_EN]   = en_q[acc_i.ch];
		csr_word[`DMA_CSR_INE]  = ine_q[acc_i.ch];
		csr_word[`DMA_CSR_DONE] = done_q[acc_i.ch];
		csr_word[`DMA_CSR_ERR]  = err_q[acc_i.ch];
		rdata_o = '0;
		if (acc_i.re) begin
			case (acc_i.idx)
				REG_CSR: rdata_o = csr_word;
				REG_SRC: rdata_o = src_q[acc_i.ch];
				REG_DST: rdata_o = dst_q[acc_i.ch];
				REG_SZ:  rdata_o = `DMA_DW'(sz_q[acc_i.ch]);
				default: rdata_o = '0;
			endcase
		end
	end

	always_comb begin
		for (int c = 0; c < `DMA_CH_COUNT; c++) begin
			desc_o[c].src  = src_q[c];
			desc_o[c].dst  = dst_q[c];
			desc_o[c].size = sz_q[c];
		end
	end

	assign en_o   = en_q;
	assign inta_o = |(ine_q & (done_q | err_q));	// Level until CSR rewritten

endmodule

//--- src/dma_slave_port.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_slave_port (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic [`DMA_DW-1:0]   wbs_adr_i,
	input  logic [`DMA_DW-1:0]   wbs_dat_i,
	input  logic [`DMA_SELW-1:0] wbs_sel_i,
	input  logic                 wbs_we_i,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic [`DMA_DW-1:0]   rf_rdata_i,
	output logic [`DMA_DW-1:0]   wbs_dat_o,
	output logic                 wbs_ack_o,
	output logic                 wbs_err_o,
	output dma_pkg::reg_acc_t    acc_o
);
	import dma_pkg::*;

	logic new_req;
	logic ch_ok;

	// Strobe seen while answering belongs to the finished access
	assign new_req = wbs_cyc_i & wbs_stb_i & ~(wbs_ack_o | wbs_err_o);
	assign ch_ok   = wbs_adr_i[`DMA_DW-1:`DMA_CH_LSB] < `DMA_CH_COUNT;

	// Register access, valid for one cycle only
	assign acc_o.re    = new_req & ch_ok & ~wbs_we_i;
	assign acc_o.we    = new_req & ch_ok & wbs_we_i & (&wbs_sel_i);	// Full words only
	assign acc_o.ch    = wbs_adr_i[`DMA_CH_LSB +: `DMA_CHW];
	assign acc_o.idx   = reg_idx_e'(wbs_adr_i[`DMA_IDX_LSB +: 2]);
	assign acc_o.wdata = wbs_dat_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wbs_ack_o <= 1'b0;
			wbs_err_o <= 1'b0;
		end else begin
			wbs_ack_o <= new_req & ch_ok;
			wbs_err_o <= new_req & ~ch_ok;	// No such channel
		end
	end

	// Read data travels with the ack
	always_ff @(posedge clk_i) begin
		if (new_req)
			wbs_dat_o <= rf_rdata_i;
	end

	a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(wbs_ack_o && wbs_err_o));

endmodule

//--- src/dma_top.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_top (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// WISHBONE slave
	input  logic [`DMA_DW-1:0]   wbs_adr_i,
	input  logic [`DMA_DW-1:0]   wbs_dat_i,
	input  logic [`DMA_SELW-1:0] wbs_sel_i,
	input  logic                 wbs_we_i,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	output logic [`DMA_DW-1:0]   wbs_dat_o,
	output logic                 wbs_ack_o,
	output logic                 wbs_err_o,
	// WISHBONE master
	input  logic [`DMA_DW-1:0]   wbm_dat_i,
	input  logic                 wbm_ack_i,
	input  logic                 wbm_err_i,
	output logic [`DMA_DW-1:0]   wbm_adr_o,
	output logic [`DMA_DW-1:0]   wbm_dat_o,
	output logic [`DMA_SELW-1:0] wbm_sel_o,
	output logic                 wbm_we_o,
	output logic                 wbm_cyc_o,
	output logic                 wbm_stb_o,
	output logic                 inta_o
);
	import dma_pkg::*;

	// ----------------------------------------
	// Internal wires
	// ----------------------------------------
	reg_acc_t                 acc;
	logic [`DMA_DW-1:0]       rf_rdata;
	logic [`DMA_CH_COUNT-1:0] ch_en;
	desc_t                    ch_desc [`DMA_CH_COUNT];
	desc_t                    sel_desc;
	logic                     de_start;
	logic [`DMA_CHW-1:0]      de_ch;
	de_status_t               de_stat;	// End of job pulse
	logic                     m_go;
	bus_req_t                 m_req;
	logic                     m_drdy;
	logic                     m_err;
	logic [`DMA_DW-1:0]       m_rdata;

	dma_slave_port u_slave (
		.clk_i(clk_i), .rst_i(rst_i),
		.wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
		.wbs_we_i(wbs_we_i), .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i),
		.rf_rdata_i(rf_rdata), .wbs_dat_o(wbs_dat_o),
		.wbs_ack_o(wbs_ack_o), .wbs_err_o(wbs_err_o), .acc_o(acc)
	);

	dma_reg_file u_rf (
		.clk_i(clk_i), .rst_i(rst_i), .acc_i(acc), .de_ch_i(de_ch),
		.de_stat_i(de_stat), .rdata_o(rf_rdata), .en_o(ch_en),
		.desc_o(ch_desc), .inta_o(inta_o)
	);

	dma_ch_sel u_sel (
		.clk_i(clk_i), .rst_i(rst_i), .en_i(ch_en), .desc_i(ch_desc),
		.de_stat_i(de_stat), .de_start_o(de_start), .desc_o(sel_desc),
		.de_ch_o(de_ch)
	);

	dma_engine u_de (
		.clk_i(clk_i), .rst_i(rst_i), .de_start_i(de_start), .desc_i(sel_desc),
		.m_drdy_i(m_drdy), .m_err_i(m_err), .m_rdata_i(m_rdata),
		.m_go_o(m_go), .m_req_o(m_req), .stat_o(de_stat)
	);

	dma_master_port u_mast (
		.clk_i(clk_i), .rst_i(rst_i), .go_i(m_go), .req_i(m_req),
		.wbm_dat_i(wbm_dat_i), .wbm_ack_i(wbm_ack_i), .wbm_err_i(wbm_err_i),
		.drdy_o(m_drdy), .err_o(m_err), .rdata_o(m_rdata),
		.wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o), .wbm_sel_o(wbm_sel_o),
		.wbm_we_o(wbm_we_o), .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o)
	);

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD = 40.0
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #(PERIOD / 2.0) clk_o = ~clk_o;	// 40 ns period

endmodule

//--- tb/tb_dma.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module tb_dma;
	import dma_pkg::*;

	localparam int CYCLE_LIMIT = 20000;	// 40 words per test, ~16 cycles each

	logic                 clk;
	logic                 rst;
	logic [`DMA_DW-1:0]   wbs_adr, wbs_dat_w, wbs_dat_r;
	logic [`DMA_SELW-1:0] wbs_sel;
	logic                 wbs_we, wbs_cyc, wbs_stb, wbs_ack, wbs_err;
	logic [`DMA_DW-1:0]   wbm_adr, wbm_dat_w, wbm_dat_r;
	logic [`DMA_SELW-1:0] wbm_sel;
	logic                 wbm_we, wbm_cyc, wbm_stb, wbm_ack, wbm_err;
	logic                 inta;
	logic [1:0]           mem_wait;

	logic [31:0] lfsr_q = 32'hb665_c23c;
	logic [31:0] ref_mem [1024];
	logic        exp_ine [`DMA_CH_COUNT];
	de_status_t  exp_st  [`DMA_CH_COUNT];
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	tb_clk_gen clkgen (.clk_o(clk));

	tb_wb_mem mem (
		.clk_i(clk), .rst_i(rst), .wait_i(mem_wait), .adr_i(wbm_adr), .dat_i(wbm_dat_w),
		.we_i(wbm_we), .cyc_i(wbm_cyc), .stb_i(wbm_stb), .dat_o(wbm_dat_r),
		.ack_o(wbm_ack), .err_o(wbm_err)
	);

	dma_top uut (
		.clk_i(clk), .rst_i(rst),
		.wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w), .wbs_sel_i(wbs_sel),
		.wbs_we_i(wbs_we), .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb),
		.wbs_dat_o(wbs_dat_r), .wbs_ack_o(wbs_ack), .wbs_err_o(wbs_err),
		.wbm_dat_i(wbm_dat_r), .wbm_ack_i(wbm_ack), .wbm_err_i(wbm_err),
		.wbm_adr_o(wbm_adr), .wbm_dat_o(wbm_dat_w), .wbm_sel_o(wbm_sel),
		.wbm_we_o(wbm_we), .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb),
		.inta_o(inta)
	);

	// ----------------------------------------
	// Random numbers
	// ----------------------------------------
	function automatic logic next_rand_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b)
			lfsr_q = lfsr_q ^ 32'h8020_0003;	// x^32+x^22+x^2+x+1
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_rand_bit()};
		return v;
	endfunction

	// New ack delay after each memory answer
	always @(posedge clk) begin
		#1;
		if (wbm_ack || wbm_err)
			mem_wait = rand_bits(2);
	end

	// Master byte select is all ones on every bus cycle
	always @(posedge clk) begin
		#1;
		if (!rst && wbm_cyc && wbm_stb)
			check_word("wbm_sel_o", 32'(wbm_sel), 32'h0000_000f);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, DMA never finished", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic de_status_t ref_copy(input logic [31:0] src, input logic [31:0] dst,
			input int n);
		logic [31:0] sa;
		logic [31:0] da;
		for (int i = 0; i < n; i++) begin
			sa = src + 32'(4 * i);
			da = dst + 32'(4 * i);
			if (sa[31] || da[31])
				return '{done: 1'b0, err: 1'b1};
			ref_mem[da[11:2]] = ref_mem[sa[11:2]];
		end
		return '{done: 1'b1, err: 1'b0};
	endfunction

	function automatic logic [31:0] ref_csr(input logic en, input logic ine, input de_status_t st);
		logic [31:0] w;
		w = '0;
		w[`DMA_CSR_EN]   = en;
		w[`DMA_CSR_INE]  = ine;
		w[`DMA_CSR_DONE] = st.done;
		w[`DMA_CSR_ERR]  = st.err;
		return w;
	endfunction

	function automatic logic ref_inta();
		logic v;
		v = 1'b0;
		for (int c = 0; c < `DMA_CH_COUNT; c++)
			v = v | (exp_ine[c] & (exp_st[c].done | exp_st[c].err));
		return v;
	endfunction

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------
	task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
			output logic [31:0] rdat, output logic err);
		@(posedge clk);
		#1;
		wbs_adr = adr;
		wbs_dat_w = dat;
		wbs_we = we;
		wbs_cyc = 1'b1;
		wbs_stb = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!wbs_ack && !wbs_err);
		rdat = wbs_dat_r;
		err = wbs_err;
		wbs_cyc = 1'b0;
		wbs_stb = 1'b0;
		wbs_we = 1'b0;
	endtask

	function automatic logic [31:0] reg_adr(input int ch, input reg_idx_e idx);
		return (32'(ch) << `DMA_CH_LSB) | (32'(idx) << `DMA_IDX_LSB);
	endfunction

	task automatic reg_write(input int ch, input reg_idx_e idx, input logic [31:0] dat);
		logic [31:0] rd;
		logic        err;
		wb_access(1'b1, reg_adr(ch, idx), dat, rd, err);
		if (err) begin
			$display("Register write to channel %0d was refused with err", ch);
			errors++;
		end
	endtask

	task automatic reg_read(input int ch, input reg_idx_e idx, output logic [31:0] dat);
		logic err;
		wb_access(1'b0, reg_adr(ch, idx), 32'h0, dat, err);
		if (err) begin
			$display("Register read from channel %0d was refused with err", ch);
			errors++;
		end
	endtask

	task automatic wait_idle(input int ch);
		logic [31:0] csr;
		do
			reg_read(ch, REG_CSR, csr);
		while (csr[`DMA_CSR_EN]);
	endtask

	task automatic set_word(input logic [31:0] adr, input logic [31:0] val);
		mem.load_word(int'(adr[11:2]), val);
		ref_mem[adr[11:2]] = val;
	endtask

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_status(input int ch, input de_status_t st);
		logic [31:0] csr;
		logic [31:0] exp;
		reg_read(ch, REG_CSR, csr);
		exp = ref_csr(1'b0, exp_ine[ch], st);
		checks += 2;
		if (csr !== exp) begin
			$display("FAILED csr[%0d] got %h expected %h", ch, csr, exp);
			errors++;
		end
		if (inta !== ref_inta()) begin
			$display("FAILED inta_o got %h expected %h", inta, ref_inta());
			errors++;
		end
	endtask

	task automatic check_region(input logic [31:0] adr, input int n);
		for (int i = 0; i < n; i++)
			check_word($sformatf("mem[%h]", adr + 32'(4 * i)),
				mem.peek_word(int'(adr[11:2]) + i), ref_mem[adr[11:2] + 10'(i)]);
	endtask

	task automatic end_test(input int num, input string name, input int err_before);
		$display("Test %0d %s: %0d errors", num, name, errors - err_before);
	endtask

	// Sets up one channel and starts it
	task automatic start_job(input int ch, input logic [31:0] src, input logic [31:0] dst,
			input int n);
		reg_write(ch, REG_SRC, src);
		reg_write(ch, REG_DST, dst);
		reg_write(ch, REG_SZ, 32'(n));
		reg_write(ch, REG_CSR, 32'h3);	// EN and INE
		exp_ine[ch] = 1'b1;
		exp_st[ch] = ref_copy(src, dst, n);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int          e0;
		logic [31:0] v;
		logic [31:0] rd;
		logic        err;

		rst = 1'b1;
		wbs_adr = '0;
		wbs_dat_w = '0;
		wbs_sel = '1;
		wbs_we = 1'b0;
		wbs_cyc = 1'b0;
		wbs_stb = 1'b0;
		mem_wait = 2'd0;
		for (int c = 0; c < `DMA_CH_COUNT; c++) begin
			exp_ine[c] = 1'b0;
			exp_st[c] = '0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		for (int c = 0; c < `DMA_CH_COUNT; c++) begin
			v = rand_bits(32);
			reg_write(c, REG_SRC, v);
			reg_read(c, REG_SRC, rd);
			check_word($sformatf("src[%0d]", c), rd, v);
			v = rand_bits(32);
			reg_write(c, REG_DST, v);
			reg_read(c, REG_DST, rd);
			check_word($sformatf("dst[%0d]", c), rd, v);
			v = rand_bits(32);
			reg_write(c, REG_SZ, v);
			reg_read(c, REG_SZ, rd);
			check_word($sformatf("sz[%0d]", c), rd, v & 32'h0000_0fff);
		end
		end_test(1, "register readback", e0);

		e0 = errors;
		for (int i = 0; i < 16; i++)
			set_word(32'h100 + 32'(4 * i), rand_bits(32));
		start_job(0, 32'h100, 32'h200, 16);
		wait_idle(0);
		check_status(0, exp_st[0]);
		check_region(32'h200, 16);
		check_word("inta_o", 32'(inta), 32'h1);
		end_test(2, "single copy", e0);

		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			set_word(32'h300 + 32'(4 * i), rand_bits(32));
			set_word(32'h500 + 32'(4 * i), rand_bits(32));
		end
		start_job(0, 32'h300, 32'h400, 8);
		start_job(1, 32'h500, 32'h600, 8);
		wait_idle(0);
		wait_idle(1);
		check_status(0, exp_st[0]);
		check_status(1, exp_st[1]);
		check_region(32'h400, 8);
		check_region(32'h600, 8);
		end_test(3, "two channels", e0);

		e0 = errors;
		for (int i = 0; i < 4; i++)
			set_word(32'h700 + 32'(4 * i), rand_bits(32));
		start_job(0, 32'h8000_0100, 32'h700, 4);
		wait_idle(0);
		check_status(0, exp_st[0]);
		check_region(32'h700, 4);
		end_test(4, "bus error", e0);

		e0 = errors;
		wb_access(1'b0, 32'(`DMA_CH_COUNT) << `DMA_CH_LSB, 32'h0, rd, err);
		checks++;
		if (!err) begin
			$display("Read of a missing channel was acknowledged instead of refused");
			errors++;
		end
		wb_access(1'b1, 32'(`DMA_CH_COUNT) << `DMA_CH_LSB, 32'h3, rd, err);
		checks++;
		if (!err) begin
			$display("Write to a missing channel was acknowledged instead of refused");
			errors++;
		end
		end_test(5, "missing channel", e0);

		e0 = errors;
		for (int c = 0; c < `DMA_CH_COUNT; c++) begin
			reg_write(c, REG_CSR, 32'h0);
			exp_ine[c] = 1'b0;
			exp_st[c] = '0;
		end
		for (int c = 0; c < `DMA_CH_COUNT; c++)
			check_status(c, exp_st[c]);
		check_word("inta_o", 32'(inta), 32'h0);
		end_test(6, "status clear", e0);

		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb/tb_wb_mem.sv
`timescale 1ns/1ps
`include "dma_defs.svh"

module tb_wb_mem (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [1:0]         wait_i,	// Wait cycles before the answer
	input  logic [`DMA_DW-1:0] adr_i,
	input  logic [`DMA_DW-1:0] dat_i,
	input  logic               we_i,
	input  logic               cyc_i,
	input  logic               stb_i,
	output logic [`DMA_DW-1:0] dat_o,
	output logic               ack_o,
	output logic               err_o
);

	logic [`DMA_DW-1:0] mem_q [1024];
	logic [1:0]         cnt_q;

	// Every word differs, built from its full address
	initial begin
		for (int i = 0; i < 1024; i++)
			mem_q[i] = (32'(i) * 32'h9e37_79b1) ^ 32'hc0de_0000;
	end

	task automatic load_word(input int idx, input logic [`DMA_DW-1:0] val);
		mem_q[idx] = val;
	endtask

	function automatic logic [`DMA_DW-1:0] peek_word(input int idx);
		return mem_q[idx];
	endfunction

	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			cnt_q <= 2'd0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			if (cyc_i && stb_i && !ack_o && !err_o) begin
				if (cnt_q == wait_i) begin
					cnt_q <= 2'd0;
					if (adr_i[31])
						err_o <= 1'b1;	// Error region
					else begin
						ack_o <= 1'b1;
						if (we_i)
							mem_q[adr_i[11:2]] = dat_i;
						else
							dat_o <= mem_q[adr_i[11:2]];
					end
				end else
					cnt_q <= cnt_q + 2'd1;
			end
		end
	end

endmodule
